//--- include/hub75_cfg.svh
`ifndef HUB75_CFG_SVH
`define HUB75_CFG_SVH

// panel width in pixels, one shift per column
`define HUB75_COLUMNS 64

// rows per half
// top and bottom halves share the row lines
`define HUB75_HALF_ROWS 16

// binary coded modulation depth
`define HUB75_PLANES 4

// lit cycles for plane 0
// plane p stays lit for this value shifted left by p
`define HUB75_BASE_DISPLAY 8

`endif

//--- src/hub75_pixel_pkg.sv
`include "hub75_cfg.svh"

package hub75_pixel_pkg;

    // one rgb565 pixel
    typedef logic [15:0] rgb565_t;

    // bottom half pixel in the upper 16 bits, top half pixel in the lower
    typedef logic [31:0] pixel_pair_t;

    typedef logic [$clog2(`HUB75_COLUMNS)-1:0] column_t;
    typedef logic [$clog2(`HUB75_HALF_ROWS)-1:0] row_t;

    // framebuffer word address, row above column
    typedef logic [$bits(row_t)+$bits(column_t)-1:0] fb_addr_t;

    // msb of each channel inside rgb565
    localparam int RED_MSB   = 15;
    localparam int GREEN_MSB = 10;
    localparam int BLUE_MSB  = 4;

endpackage

//--- src/hub75_scan_pkg.sv
`include "hub75_cfg.svh"

package hub75_scan_pkg;

    // bitplane index, lsb plane first
    typedef logic [$clog2(`HUB75_PLANES)-1:0] plane_t;

    // per column: fetch, clock high, clock low
    // per plane: latch once, then display
    typedef enum logic [2:0] {
        S_FETCH,
        S_CLK_HIGH,
        S_CLK_LOW,
        S_LATCH,
        S_DISPLAY
    } scan_state_t;

endpackage

//--- src/hub75_ifs.sv
`timescale 1ns/1ps

// request and return path between the scan FSM and the framebuffer fetch
interface fb_fetch_if;
    import hub75_pixel_pkg::*;

    column_t column;
    row_t    row;
    // one cycle pulse, column and row must hold until done
    logic    start;
    // marks the capture edge, pair is held from the next cycle
    logic    done;
    rgb565_t top;
    rgb565_t bottom;

    modport requester (output column, row, start, input done, top, bottom);
    modport fetcher (input column, row, start, output done, top, bottom);
endinterface

// everything the pin stage needs, one cycle ahead of the pins
interface panel_drive_if;
    import hub75_pixel_pkg::*;
    import hub75_scan_pkg::*;

    rgb565_t top;
    rgb565_t bottom;
    plane_t  plane;
    logic    shift;
    logic    latch;
    logic    display;
    row_t    row;

    modport source (output top, bottom, plane, shift, latch, display, row);
    modport sink (input top, bottom, plane, shift, latch, display, row);
endinterface

//--- src/framebuffer_ram.sv
`timescale 1ns/1ps

module framebuffer_ram (
    input  logic                         clk_in,
    input  logic                         reset,
    input  logic                         wr_valid,
    output logic                         wr_ready,
    input  hub75_pixel_pkg::fb_addr_t    wr_addr,
    input  hub75_pixel_pkg::pixel_pair_t wr_data,
    input  logic                         ram_enable,
    input  hub75_pixel_pkg::fb_addr_t    ram_address,
    output hub75_pixel_pkg::pixel_pair_t ram_data
);
    import hub75_pixel_pkg::*;

    localparam int DEPTH = 1 << $bits(fb_addr_t);

    // one word per row and column, both halves side by side
    pixel_pair_t mem [0:DEPTH-1];

    // the fetch owns the single port while it runs
    assign wr_ready = !ram_enable;

    always_ff @(posedge clk_in) begin
        if (ram_enable) begin
            // read, one cycle latency
            ram_data <= mem[ram_address];
        end
        else if (wr_valid) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // a write waiting behind a fetch leaves the memory untouched
    a_no_write_while_reading: assert property (
        @(posedge clk_in) disable iff (reset)
        (wr_valid && ram_enable) |=> mem[$past(wr_addr)] == $past(mem[wr_addr])
    );

endmodule

//--- src/framebuffer_fetch.sv
`timescale 1ns/1ps

module framebuffer_fetch (
    input  logic                         clk_in,
    input  logic                         reset,
    fb_fetch_if.fetcher                  fetch,
    output hub75_pixel_pkg::fb_addr_t    ram_address,
    output logic                         ram_enable,
    input  hub75_pixel_pkg::pixel_pair_t ram_data
);
    import hub75_pixel_pkg::*;

    // 3 on start, then down to 0
    logic [1:0] load_count;

    // row and column stay put from start through the capture
    assign ram_address = {fetch.row, fetch.column};

    // holds the port for counts 3, 2 and 1
    assign ram_enable = (load_count != 2'd0);

    // capture edge, the controller moves on as the pair lands
    assign fetch.done = (load_count == 2'd1);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            load_count <= 2'd0;
        end
        else if (fetch.start) begin
            load_count <= 2'd3;
        end
        else if (load_count != 2'd0) begin
            load_count <= load_count - 2'd1;
        end
    end

    // count 3: address out, RAM samples it
    // count 2: RAM data valid
    // count 1: take the pair
    always_ff @(posedge clk_in) begin
        if (load_count == 2'd1) begin
            {fetch.bottom, fetch.top} <= ram_data;
        end
    end

    // the scan FSM must wait for done before the next request
    a_start_idle: assert property (
        @(posedge clk_in) disable iff (reset)
        fetch.start |-> load_count == 2'd0
    );

endmodule

//--- src/scan_controller.sv
`timescale 1ns/1ps

`include "hub75_cfg.svh"

module scan_controller (
    input  logic            clk_in,
    input  logic            reset,
    fb_fetch_if.requester   fetch,
    panel_drive_if.source   panel
);
    import hub75_pixel_pkg::*;
    import hub75_scan_pkg::*;

    localparam column_t LAST_COLUMN = column_t'(`HUB75_COLUMNS - 1);
    localparam plane_t  LAST_PLANE  = plane_t'(`HUB75_PLANES - 1);
    // longest plane sets the width of the display counter
    localparam int MAX_DISPLAY = `HUB75_BASE_DISPLAY << (`HUB75_PLANES - 1);
    localparam int DISP_W = $clog2(MAX_DISPLAY);

    scan_state_t state;
    scan_state_t state_next;
    column_t     col_q;
    row_t        row_q;
    plane_t      plane_q;
    logic [DISP_W-1:0] disp_count;
    // kicks the very first fetch after reset
    logic        boot_q;
    logic        start_pulse;

    // start is issued on the edge that enters S_FETCH
    // so the fetch state itself takes exactly three cycles
    always_comb begin
        state_next  = state;
        start_pulse = boot_q;
        case (state)
            S_FETCH: begin
                if (fetch.done) begin
                    state_next = S_CLK_HIGH;
                end
            end
            S_CLK_HIGH: begin
                state_next = S_CLK_LOW;
            end
            S_CLK_LOW: begin
                if (col_q == LAST_COLUMN) begin
                    state_next = S_LATCH;
                end
                else begin
                    state_next  = S_FETCH;
                    start_pulse = 1'b1;
                end
            end
            S_LATCH: begin
                state_next = S_DISPLAY;
            end
            S_DISPLAY: begin
                // next plane or next row starts shifting right away
                if (disp_count == '0) begin
                    state_next  = S_FETCH;
                    start_pulse = 1'b1;
                end
            end
            default: begin
                state_next = S_FETCH;
            end
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state      <= S_FETCH;
            col_q      <= '0;
            row_q      <= '0;
            plane_q    <= '0;
            disp_count <= '0;
            boot_q     <= 1'b1;
        end
        else begin
            boot_q <= 1'b0;
            state  <= state_next;
            // wraps 63 to 0 going into the latch
            if (state == S_CLK_LOW) begin
                col_q <= column_t'(col_q + 1'b1);
            end
            // binary weighted on time, plane p lasts base << p cycles
            if (state == S_LATCH) begin
                disp_count <= DISP_W'((`HUB75_BASE_DISPLAY << plane_q) - 1);
            end
            else if (state == S_DISPLAY && disp_count != '0) begin
                disp_count <= disp_count - 1'b1;
            end
            // planes 0..3 per row, row moves while oe is off
            if (state == S_DISPLAY && disp_count == '0) begin
                plane_q <= plane_t'(plane_q + 1'b1);
                if (plane_q == LAST_PLANE) begin
                    row_q <= row_t'(row_q + 1'b1);
                end
            end
        end
    end

    assign fetch.start  = start_pulse;
    assign fetch.column = col_q;
    assign fetch.row    = row_q;

    assign panel.top     = fetch.top;
    assign panel.bottom  = fetch.bottom;
    assign panel.plane   = plane_q;
    assign panel.shift   = (state == S_CLK_HIGH);
    assign panel.latch   = (state == S_LATCH);
    assign panel.display = (state == S_DISPLAY);
    assign panel.row     = row_q;

    // lit only after a latch, never while shifting or latching
    a_display_after_latch: assert property (
        @(posedge clk_in) disable iff (reset)
        panel.display |-> !panel.shift && !panel.latch &&
                          $past(panel.latch || panel.display)
    );

    // a latch follows the last column, so the count stays within 0..63
    a_latch_on_wrap: assert property (
        @(posedge clk_in) disable iff (reset)
        panel.latch |-> col_q == '0 && $past(col_q) == LAST_COLUMN
    );

endmodule

//--- src/hub75_output.sv
`timescale 1ns/1ps

`include "hub75_cfg.svh"

module hub75_output (
    input  logic                  clk_in,
    input  logic                  reset,
    panel_drive_if.sink           panel,
    output logic                  r1,
    output logic                  g1,
    output logic                  b1,
    output logic                  r2,
    output logic                  g2,
    output logic                  b2,
    output logic                  panel_clk,
    output logic                  lat,
    output logic                  oe_n,
    output hub75_pixel_pkg::row_t row_sel
);
    import hub75_pixel_pkg::*;
    import hub75_scan_pkg::*;

    // top HUB75_PLANES bits of a channel, plane 0 is the lowest of them
    function automatic logic plane_bit(rgb565_t px, int msb, plane_t plane);
        int index;
        index = msb - (`HUB75_PLANES - 1) + int'(plane);
        return px[index];
    endfunction

    always_ff @(posedge clk_in) begin
        if (reset) begin
            r1        <= 1'b0;
            g1        <= 1'b0;
            b1        <= 1'b0;
            r2        <= 1'b0;
            g2        <= 1'b0;
            b2        <= 1'b0;
            panel_clk <= 1'b0;
            lat       <= 1'b0;
            oe_n      <= 1'b1;
            row_sel   <= '0;
        end
        else begin
            panel_clk <= panel.shift;
            lat       <= panel.latch;
            // active low enable
            oe_n      <= !panel.display;
            row_sel   <= panel.row;
            // colors change with the clock rising and hold until the next shift
            if (panel.shift) begin
                r1 <= plane_bit(panel.top, RED_MSB, panel.plane);
                g1 <= plane_bit(panel.top, GREEN_MSB, panel.plane);
                b1 <= plane_bit(panel.top, BLUE_MSB, panel.plane);
                r2 <= plane_bit(panel.bottom, RED_MSB, panel.plane);
                g2 <= plane_bit(panel.bottom, GREEN_MSB, panel.plane);
                b2 <= plane_bit(panel.bottom, BLUE_MSB, panel.plane);
            end
        end
    end

endmodule

//--- src/hub75_top.sv
`timescale 1ns/1ps

module hub75_top (
    input  logic                         clk_in,
    input  logic                         reset,
    // host write port
    input  logic                         wr_valid,
    output logic                         wr_ready,
    input  hub75_pixel_pkg::row_t        wr_row,
    input  hub75_pixel_pkg::column_t     wr_column,
    input  hub75_pixel_pkg::pixel_pair_t wr_data,
    // panel pins
    output logic                         r1,
    output logic                         g1,
    output logic                         b1,
    output logic                         r2,
    output logic                         g2,
    output logic                         b2,
    output logic                         panel_clk,
    output logic                         lat,
    output logic                         oe_n,
    output hub75_pixel_pkg::row_t        row_sel
);
    import hub75_pixel_pkg::*;

    fb_addr_t    ram_address;
    logic        ram_enable;
    pixel_pair_t ram_data;

    fb_fetch_if    fetch_bus ();
    panel_drive_if panel_bus ();

    // host side uses the same row over column layout as the fetch
    framebuffer_ram framebuffer_ram_inst (
        .clk_in(clk_in), .reset(reset), .wr_valid(wr_valid), .wr_ready(wr_ready),
        .wr_addr({wr_row, wr_column}), .wr_data(wr_data), .ram_enable(ram_enable),
        .ram_address(ram_address), .ram_data(ram_data)
    );

    framebuffer_fetch framebuffer_fetch_inst (
        .clk_in(clk_in), .reset(reset), .fetch(fetch_bus.fetcher),
        .ram_address(ram_address), .ram_enable(ram_enable), .ram_data(ram_data)
    );

    scan_controller scan_controller_inst (
        .clk_in(clk_in), .reset(reset), .fetch(fetch_bus.requester),
        .panel(panel_bus.source)
    );

    hub75_output hub75_output_inst (
        .clk_in(clk_in), .reset(reset), .panel(panel_bus.sink),
        .r1(r1), .g1(g1), .b1(b1), .r2(r2), .g2(g2), .b2(b2),
        .panel_clk(panel_clk), .lat(lat), .oe_n(oe_n), .row_sel(row_sel)
    );

endmodule

//--- sim/tb_hub75.sv
`timescale 1ns/1ps

`include "hub75_cfg.svh"

module tb_hub75;
    import hub75_pixel_pkg::*;

    localparam int DEPTH = 1 << $bits(fb_addr_t);
    localparam int COLUMNS = `HUB75_COLUMNS;
    localparam int PHASES_PER_FRAME = `HUB75_HALF_ROWS * `HUB75_PLANES;
    // per column 3 fetch and 2 clock cycles, then one latch per phase
    localparam int ROW_CYCLES = `HUB75_PLANES * (COLUMNS * 5 + 1)
                              + `HUB75_BASE_DISPLAY * ((1 << `HUB75_PLANES) - 1);
    localparam int FRAME_CYCLES = `HUB75_HALF_ROWS * ROW_CYCLES;
    // fill at up to 8 cycles a word, two checked frames, and wide margin
    localparam int TIMEOUT_CYCLES = 5 * FRAME_CYCLES + 8 * DEPTH;

    logic        clk_in;
    logic        reset;
    logic        wr_valid;
    logic        wr_ready;
    row_t        wr_row;
    column_t     wr_column;
    pixel_pair_t wr_data;
    logic        r1;
    logic        g1;
    logic        b1;
    logic        r2;
    logic        g2;
    logic        b2;
    logic        panel_clk;
    logic        lat;
    logic        oe_n;
    row_t        row_sel;

    // reference copy of the framebuffer
    pixel_pair_t model [0:DEPTH-1];
    int          cycle_count = 0;
    int          reset_cycles = 0;
    // pulses since the last latch, this is the column being shown
    int          clk_count;
    int          lat_count;
    int          low_count;
    int          busy_run;
    int          checked_pixels;
    logic        oe_prev;
    logic        lat_prev;
    logic        colors_live;
    pixel_pair_t pair_now;
    logic [5:0]  pins;
    logic [5:0]  exp_pins;

    hub75_top hub75_top_inst (
        .clk_in(clk_in), .reset(reset), .wr_valid(wr_valid), .wr_ready(wr_ready),
        .wr_row(wr_row), .wr_column(wr_column), .wr_data(wr_data),
        .r1(r1), .g1(g1), .b1(b1), .r2(r2), .g2(g2), .b2(b2),
        .panel_clk(panel_clk), .lat(lat), .oe_n(oe_n), .row_sel(row_sel)
    );

    initial clk_in = 1'b0;
    always #10 clk_in = ~clk_in;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    // red sits in bits 12..15, green 7..10, blue 1..4, plane p is lowest + p
    function automatic logic [2:0] rgb_bits(input rgb565_t px, input int plane);
        logic [2:0] bits;
        bits[2] = px[12 + plane];
        bits[1] = px[7 + plane];
        bits[0] = px[1 + plane];
        return bits;
    endfunction

    // holds the request until wr_ready is seen at a rising edge
    task automatic write_pair(input fb_addr_t addr, input pixel_pair_t data);
        logic taken;
        wr_valid = 1'b1;
        {wr_row, wr_column} = addr;
        wr_data = data;
        do begin
            taken = wr_ready;
            @(negedge clk_in);
        end while (!taken);
        wr_valid = 1'b0;
    endtask

    // phase k shows row k / 4 at plane k % 4
    always_comb begin
        pair_now = model[{row_t'(lat_count / `HUB75_PLANES), column_t'(clk_count)}];
        exp_pins = {rgb_bits(pair_now[15:0], lat_count % `HUB75_PLANES),
                    rgb_bits(pair_now[31:16], lat_count % `HUB75_PLANES)};
    end
    assign pins = {r1, g1, b1, r2, g2, b2};

    always @(posedge clk_in) begin
        if (!reset && wr_valid && wr_ready) begin
            model[{wr_row, wr_column}] <= wr_data;
        end
    end

    always @(posedge clk_in) begin
        if (reset) begin
            reset_cycles   <= reset_cycles + 1;
            clk_count      <= 0;
            lat_count      <= 0;
            low_count      <= 0;
            busy_run       <= 0;
            checked_pixels <= 0;
            oe_prev        <= 1'b1;
            lat_prev       <= 1'b0;
        end
        else begin
            clk_count      <= lat ? 0 : clk_count + int'(panel_clk);
            lat_count      <= lat_count + int'(lat);
            low_count      <= oe_n ? 0 : low_count + 1;
            busy_run       <= wr_ready ? 0 : busy_run + 1;
            checked_pixels <= checked_pixels + int'(colors_live && panel_clk);
            oe_prev        <= oe_n;
            lat_prev       <= lat;
        end
    end

    always @(posedge clk_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run("timeout before two full frames were shown");
        end
    end

    // registered pins idle once reset has been seen at an edge
    a_reset_idle: assert property (@(posedge clk_in)
        reset && reset_cycles > 0 |-> oe_n && !lat && !panel_clk && pins == '0 && wr_ready)
        else fail_run($sformatf("Fail oe_n %h lat %h panel_clk %h pins %h wr_ready %h",
            $sampled(oe_n), $sampled(lat), $sampled(panel_clk), $sampled(pins),
            $sampled(wr_ready)));
    a_ready_out_of_reset: assert property (@(posedge clk_in) $fell(reset) |-> wr_ready)
        else fail_run("wr_ready was low on the first cycle after reset");
    // a fetch owns the RAM for exactly three cycles
    a_fetch_busy: assert property (@(posedge clk_in) disable iff (reset)
        wr_ready && busy_run != 0 |-> busy_run == 3)
        else fail_run($sformatf("Fail wr_ready low run got %h expected %h",
            $sampled(busy_run), 3));
    a_colors: assert property (@(posedge clk_in) disable iff (reset)
        colors_live && panel_clk |-> pins == exp_pins)
        else fail_run($sformatf("Fail {r1,g1,b1,r2,g2,b2} got %h expected %h row %h col %h",
            $sampled(pins), $sampled(exp_pins), $sampled(row_sel), $sampled(clk_count)));
    a_clk_single: assert property (@(posedge clk_in) disable iff (reset)
        panel_clk |=> !panel_clk && $past(clk_count) < COLUMNS)
        else fail_run("panel_clk stayed high or ran past the last column");
    a_lat_columns: assert property (@(posedge clk_in) disable iff (reset)
        lat |-> clk_count == COLUMNS)
        else fail_run($sformatf("Fail panel_clk count at lat got %h expected %h",
            $sampled(clk_count), COLUMNS));
    a_lat_dark: assert property (@(posedge clk_in) disable iff (reset)
        lat |-> oe_n ##1 !lat)
        else fail_run("lat was longer than one cycle or came with oe_n low");
    a_row_order: assert property (@(posedge clk_in) disable iff (reset)
        lat || panel_clk |-> row_sel == row_t'(lat_count / `HUB75_PLANES))
        else fail_run($sformatf("Fail row_sel got %h expected %h", $sampled(row_sel),
            row_t'($sampled(lat_count) / `HUB75_PLANES)));
    // lit straight after the latch, for base << plane cycles
    a_lit_after_lat: assert property (@(posedge clk_in) disable iff (reset)
        !oe_n && oe_prev |-> lat_prev)
        else fail_run("oe_n went low without a latch just before");
    a_display_time: assert property (@(posedge clk_in) disable iff (reset)
        oe_n && !oe_prev |->
            low_count == (`HUB75_BASE_DISPLAY << ((lat_count - 1) % `HUB75_PLANES)))
        else fail_run($sformatf("Fail oe_n low run got %h expected %h", $sampled(low_count),
            `HUB75_BASE_DISPLAY << (($sampled(lat_count) - 1) % `HUB75_PLANES)));

    initial begin
        int unsigned addr;
        int          frame_start;
        void'($urandom(32'hdcbb));
        reset       = 1'b1;
        wr_valid    = 1'b0;
        wr_row      = '0;
        wr_column   = '0;
        wr_data     = '0;
        colors_live = 1'b0;
        repeat (16) @(negedge clk_in);
        reset = 1'b0;
        for (addr = 0; addr < DEPTH; addr++) begin
            write_pair(fb_addr_t'(addr), $urandom());
        end
        // the phase after the next latch is fetched entirely after the fill
        frame_start = lat_count;
        while (lat_count == frame_start) @(negedge clk_in);
        colors_live = 1'b1;
        frame_start = lat_count;
        while (lat_count < frame_start + PHASES_PER_FRAME) @(negedge clk_in);
        // host traffic rewrites stored pairs so the picture stays fixed
        while (lat_count < frame_start + 2 * PHASES_PER_FRAME) begin
            if ($urandom_range(1, 0) == 1) begin
                addr = $urandom_range(DEPTH - 1, 0);
                write_pair(fb_addr_t'(addr), model[addr]);
            end
            else begin
                @(negedge clk_in);
            end
        end
        colors_live = 1'b0;
        if (checked_pixels != 2 * PHASES_PER_FRAME * COLUMNS) begin
            fail_run($sformatf("only %0d pixels reached the color check", checked_pixels));
        end
        else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

//--- vlog.f
+incdir+include
src/hub75_pixel_pkg.sv
src/hub75_scan_pkg.sv
src/hub75_ifs.sv
src/framebuffer_ram.sv
src/framebuffer_fetch.sv
src/scan_controller.sv
src/hub75_output.sv
src/hub75_top.sv
sim/tb_hub75.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_hub75
FILELIST = vlog.f
BUILD    = obj_dir
LOG      = sim.log
PASS     = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# the log decides the result, a missing pass line fails the target
run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
